// ==== mem_subsystem.f ====
src/mem_pkg.sv
src/mem_request_arbiter.sv
src/mem_pipeline.sv
src/mem_response_queue.sv
src/mem_subsystem.sv
testbench/mem_subsystem_properties.sv
testbench/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_mem_subsystem \
    -f mem_subsystem.f \
    -o sim_mem_subsystem

./obj_dir/sim_mem_subsystem > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== src/mem_pipeline.sv ====
`timescale 1ns/10ps

module mem_pipeline (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_cmd_t i_cmd,
    input  logic              i_queue_full,
    output logic              o_stall,
    output mem_pkg::mem_rsp_t o_push_rsp
);
    import mem_pkg::*;

    mem_cmd_t          stage_q [STAGES];   // latency stages, 0 is the entry
    logic [DATA_W-1:0] mem_q   [LINES];    // line storage

    // read result register towards the queue
    logic              push_vld_q;
    logic [DATA_W-1:0] push_data_q;
    logic [TAG_W-1:0]  push_tag_q;
    logic [PORT_W-1:0] push_port_q;

    mem_cmd_t last;      // command in the final stage
    logic     last_rd;
    logic     last_wr;
    logic     advance;   // stages move this edge

    assign last    = stage_q[STAGES-1];
    assign last_rd = last.req.valid && (last.req.op == OP_READ);
    assign last_wr = last.req.valid && (last.req.op == OP_WRITE);

    // only a read needs room in the queue, writes always retire
    assign o_stall = last_rd && i_queue_full;
    assign advance = !o_stall;

    // shift register of commands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else if (advance) begin
            stage_q[0] <= i_cmd;   // arbiter sends an invalid command while stalled
            for (int i = 1; i < STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // storage access at the last stage
    always_ff @(posedge clk) begin
        if (last_wr && advance) begin
            mem_q[last.req.addr] <= last.req.data;
        end
    end

    // push strobe for the queue
    // during a stall the pending push still lands, so the strobe drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            push_vld_q <= 1'b0;
        end else begin
            push_vld_q <= last_rd && advance;
        end
    end

    always_ff @(posedge clk) begin
        if (last_rd && advance) begin
            push_data_q <= mem_q[last.req.addr];
            push_tag_q  <= last.req.tag;
            push_port_q <= last.port;
        end
    end

    always_comb begin
        o_push_rsp.valid = push_vld_q;
        o_push_rsp.data  = push_data_q;
        o_push_rsp.tag   = push_tag_q;
        o_push_rsp.port  = push_port_q;
    end

endmodule

// ==== src/mem_pkg.sv ====
package mem_pkg;

    // line memory geometry
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int LINES  = 1 << ADDR_W;   // 256 lines

    // requester side
    localparam int TAG_W   = 4;     // requester's own transaction tag
    localparam int N_PORTS = 2;
    localparam int PORT_W  = 1;

    // latency and buffering
    localparam int STAGES      = 5;
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);   // holds 0..QUEUE_DEPTH

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // one request as offered by a requester, 46 bits
    typedef struct packed {
        logic              valid;
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;   // write data, ignored for reads
        logic [TAG_W-1:0]  tag;
    } mem_req_t;

    // request after arbitration, tagged with its port
    typedef struct packed {
        mem_req_t          req;
        logic [PORT_W-1:0] port;
    } mem_cmd_t;

    // read result, 38 bits
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
        logic [TAG_W-1:0]  tag;
        logic [PORT_W-1:0] port;   // owner of the result
    } mem_rsp_t;

endpackage

// ==== src/mem_request_arbiter.sv ====
`timescale 1ns/10ps

module mem_request_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  mem_pkg::mem_req_t           i_req [mem_pkg::N_PORTS],
    input  logic                        i_stall,
    output logic [mem_pkg::N_PORTS-1:0] o_req_ready,
    output mem_pkg::mem_cmd_t           o_cmd
);
    import mem_pkg::*;

    logic [N_PORTS-1:0] req_vld;
    logic [PORT_W-1:0]  last_q;    // port granted most recently
    logic [PORT_W-1:0]  pick;      // candidate winner this cycle
    logic               grant;

    always_comb begin
        for (int p = 0; p < N_PORTS; p++) begin
            req_vld[p] = i_req[p].valid;
        end
    end

    // round robin between the two ports
    // on a conflict the port not served last wins
    always_comb begin
        if (&req_vld) begin
            pick = ~last_q;
        end else if (req_vld[1]) begin
            pick = PORT_W'(1);
        end else begin
            pick = PORT_W'(0);
        end
    end

    // nothing goes out during reset or while the pipeline is frozen
    assign grant = (|req_vld) && !i_stall && !rst;

    always_comb begin
        for (int p = 0; p < N_PORTS; p++) begin
            o_req_ready[p] = grant && (pick == PORT_W'(p));
        end
    end

    // command to stage 0, valid only when granted
    always_comb begin
        o_cmd.req       = i_req[pick];
        o_cmd.req.valid = grant;
        o_cmd.port      = pick;
    end

    // reset to port 1 so port 0 wins the first conflict
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_q <= PORT_W'(1);
        end else if (grant) begin
            last_q <= pick;
        end
    end

endmodule

// ==== src/mem_response_queue.sv ====
`timescale 1ns/10ps

module mem_response_queue (
    input  logic                        clk,
    input  logic                        rst,
    input  mem_pkg::mem_rsp_t           i_push_rsp,
    input  logic [mem_pkg::N_PORTS-1:0] i_rsp_ack,
    output logic                        o_queue_full,
    output mem_pkg::mem_rsp_t           o_rsp [mem_pkg::N_PORTS]
);
    import mem_pkg::*;

    mem_rsp_t          entry_q [QUEUE_DEPTH];   // result storage
    logic [QPTR_W-1:0] wr_ptr_q;
    logic [QPTR_W-1:0] rd_ptr_q;
    logic [QCNT_W-1:0] count_q;

    mem_rsp_t head;
    logic     not_empty;
    logic     push;
    logic     pop;

    function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] ptr);
        if (ptr == QPTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + QPTR_W'(1);
    endfunction

    assign head      = entry_q[rd_ptr_q];
    assign not_empty = (count_q != '0);
    assign push      = i_push_rsp.valid;
    assign pop       = not_empty && i_rsp_ack[head.port];   // only the owner can release it

    // a push already on its way takes the last free slot
    assign o_queue_full = (count_q == QCNT_W'(QUEUE_DEPTH)) ||
                          ((count_q == QCNT_W'(QUEUE_DEPTH - 1)) && push);

    // head shows on its own port only, the other port waits
    always_comb begin
        for (int p = 0; p < N_PORTS; p++) begin
            o_rsp[p]       = head;
            o_rsp[p].valid = not_empty && (head.port == PORT_W'(p));
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry_q[wr_ptr_q] <= i_push_rsp;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // push and pop together leave the count alone
            if (push && !pop) begin
                count_q <= count_q + QCNT_W'(1);
            end else if (pop && !push) begin
                count_q <= count_q - QCNT_W'(1);
            end
        end
    end

endmodule

// ==== src/mem_subsystem.sv ====
`timescale 1ns/10ps

module mem_subsystem (
    input  logic                        clk,
    input  logic                        rst,
    input  mem_pkg::mem_req_t           i_req [mem_pkg::N_PORTS],
    output logic [mem_pkg::N_PORTS-1:0] o_req_ready,
    output mem_pkg::mem_rsp_t           o_rsp [mem_pkg::N_PORTS],
    input  logic [mem_pkg::N_PORTS-1:0] i_rsp_ack
);
    import mem_pkg::*;

    mem_cmd_t cmd;          // arbiter to stage 0
    logic     stall;        // pipeline frozen
    mem_rsp_t push_rsp;     // read result into the queue
    logic     queue_full;

    // picks one requester per cycle
    mem_request_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_req       (i_req),
        .i_stall     (stall),
        .o_req_ready (o_req_ready),
        .o_cmd       (cmd)
    );

    // fixed latency stages plus the line storage
    mem_pipeline u_pipeline (
        .clk          (clk),
        .rst          (rst),
        .i_cmd        (cmd),
        .i_queue_full (queue_full),
        .o_stall      (stall),
        .o_push_rsp   (push_rsp)
    );

    // in-order return of read data
    mem_response_queue u_response_queue (
        .clk          (clk),
        .rst          (rst),
        .i_push_rsp   (push_rsp),
        .i_rsp_ack    (i_rsp_ack),
        .o_queue_full (queue_full),
        .o_rsp        (o_rsp)
    );

endmodule

// ==== testbench/mem_subsystem_properties.sv ====
`timescale 1ns/10ps

module mem_subsystem_properties (
    input logic                        clk,
    input logic                        rst,
    input mem_pkg::mem_req_t           i_req [mem_pkg::N_PORTS],
    input logic [mem_pkg::N_PORTS-1:0] o_req_ready,
    input mem_pkg::mem_rsp_t           o_rsp [mem_pkg::N_PORTS]
);
    import mem_pkg::*;

    // one grant per cycle at most
    a_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(o_req_ready))
        else $error("more than one ready at a time");

    // a grant needs a valid request behind it
    a_ready_port0: assert property (@(posedge clk) disable iff (rst)
        o_req_ready[0] |-> i_req[0].valid)
        else $error("ready on port 0 without a valid request");

    a_ready_port1: assert property (@(posedge clk) disable iff (rst)
        o_req_ready[1] |-> i_req[1].valid)
        else $error("ready on port 1 without a valid request");

    // only the head owner sees a result
    a_rsp_one_port: assert property (@(posedge clk) disable iff (rst)
        !(o_rsp[0].valid && o_rsp[1].valid))
        else $error("response valid on both ports");

    a_quiet_in_reset: assert property (@(posedge clk)
        rst |-> (o_req_ready == '0 && !o_rsp[0].valid && !o_rsp[1].valid))
        else $error("ready or response valid during reset");

endmodule

bind mem_subsystem mem_subsystem_properties u_properties (
    .clk         (clk),
    .rst         (rst),
    .i_req       (i_req),
    .o_req_ready (o_req_ready),
    .o_rsp       (o_rsp)
);

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/10ps

module tb_mem_subsystem;
    import mem_pkg::*;

    logic               clk;
    logic               rst;
    mem_req_t           i_req [N_PORTS];
    logic [N_PORTS-1:0] o_req_ready;
    mem_rsp_t           o_rsp [N_PORTS];
    logic [N_PORTS-1:0] i_rsp_ack;

    logic [DATA_W-1:0] model_mem [LINES];   // expected line contents
    mem_rsp_t          exp_q [$];           // reads in acceptance order
    mem_req_t          dir_q0 [$];          // directed requests per port
    mem_req_t          dir_q1 [$];
    int                acc_cnt [N_PORTS];
    int                last_gnt;            // port granted most recently
    bit                rand_en;
    bit                rd_heavy;
    int                ack_mode;            // 0 high, 1 random, 2 low
    int                rsp_errs;
    int                ready_errs;
    int                other_errs;
    int                lat;

    mem_subsystem u_mem_subsystem (
        .clk         (clk),
        .rst         (rst),
        .i_req       (i_req),
        .o_req_ready (o_req_ready),
        .o_rsp       (o_rsp),
        .i_rsp_ack   (i_rsp_ack)
    );

    always #5 clk = ~clk;

    task automatic check_rsp(input int p, input mem_rsp_t got, input mem_rsp_t exp);
        if (got.valid !== exp.valid) begin
            $display("error: o_rsp[%0d].valid got %h expected %h", p, got.valid, exp.valid);
            rsp_errs++;
        end else if (exp.valid) begin
            if (PORT_W'(p) !== exp.port) begin
                $display("error: o_rsp delivery port got %h expected %h", PORT_W'(p), exp.port);
                rsp_errs++;
            end
            if (got.data !== exp.data) begin
                $display("error: o_rsp[%0d].data got %h expected %h", p, got.data, exp.data);
                rsp_errs++;
            end
            if (got.tag !== exp.tag) begin
                $display("error: o_rsp[%0d].tag got %h expected %h", p, got.tag, exp.tag);
                rsp_errs++;
            end
            if (got.port !== exp.port) begin
                $display("error: o_rsp[%0d].port got %h expected %h", p, got.port, exp.port);
                rsp_errs++;
            end
        end
    endtask

    task automatic check_ready(input string what, input logic [N_PORTS-1:0] got,
                               input logic [N_PORTS-1:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", what, got, exp);
            ready_errs++;
        end
    endtask

    function automatic mem_req_t random_req();
        mem_req_t r;
        r.valid = 1'b1;
        r.op    = (($urandom % 10) < (rd_heavy ? 9 : 5)) ? OP_READ : OP_WRITE;
        r.addr  = ADDR_W'($urandom);
        r.data  = DATA_W'($urandom);
        r.tag   = TAG_W'($urandom);
        return r;
    endfunction

    // requesters, holding each request until it is taken
    always @(posedge clk) begin
        mem_req_t nxt;
        bit       have;
        if (!rst) begin
            for (int p = 0; p < N_PORTS; p++) begin
                have = 1'b0;
                if (i_req[p].valid && !o_req_ready[p]) begin
                    continue;
                end
                if (p == 0 && dir_q0.size() > 0) begin
                    nxt  = dir_q0.pop_front();
                    have = 1'b1;
                end else if (p == 1 && dir_q1.size() > 0) begin
                    nxt  = dir_q1.pop_front();
                    have = 1'b1;
                end else if (rand_en && ($urandom % 4) != 0) begin
                    nxt  = random_req();
                    have = 1'b1;
                end
                if (have) begin
                    i_req[p] <= nxt;
                end else begin
                    i_req[p].valid <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            case (ack_mode)
                0: i_rsp_ack <= '1;
                1: i_rsp_ack <= N_PORTS'($urandom);
                default: i_rsp_ack <= '0;
            endcase
        end
    end

    // model of the memory, the arbiter and the response order
    always @(posedge clk) begin
        mem_rsp_t e;
        mem_req_t r;
        logic [N_PORTS-1:0] vld;
        if (!rst) begin
            vld = {i_req[1].valid, i_req[0].valid};
            check_ready("o_req_ready without valid", o_req_ready & ~vld, '0);
            if (&vld && |o_req_ready) begin
                check_ready("o_req_ready on conflict", o_req_ready,
                            (last_gnt == 0) ? 2'b10 : 2'b01);
            end
            for (int p = 0; p < N_PORTS; p++) begin
                if (o_req_ready[p]) begin
                    r = i_req[p];
                    acc_cnt[p]++;
                    last_gnt = p;
                    if (r.op == OP_WRITE) begin
                        model_mem[r.addr] = r.data;
                    end else begin
                        e.valid = 1'b1;
                        e.data  = model_mem[r.addr];
                        e.tag   = r.tag;
                        e.port  = PORT_W'(p);
                        exp_q.push_back(e);
                    end
                end
            end
            for (int p = 0; p < N_PORTS; p++) begin
                if (o_rsp[p].valid && i_rsp_ack[p]) begin
                    if (exp_q.size() == 0) begin
                        $display("port %0d handed over a result that nobody asked for", p);
                        other_errs++;
                    end else begin
                        e = exp_q.pop_front();
                        check_rsp(p, o_rsp[p], e);
                    end
                end
            end
        end
    end

    task automatic wait_accepts(input int p, input int target, input int limit);
        int n;
        n = 0;
        while (acc_cnt[p] < target) begin
            @(posedge clk);
            #1;
            n++;
            if (n > limit) begin
                $display("port %0d: requests were not accepted in time", p);
                other_errs++;
                break;
            end
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 || i_req[0].valid || i_req[1].valid) begin
            @(posedge clk);
            #1;
            n++;
            if (n > limit) begin
                $display("outstanding reads did not come back in time");
                other_errs++;
                break;
            end
        end
    endtask

    task automatic measure_latency();
        mem_req_t r;
        int       n;
        r       = '0;
        r.valid = 1'b1;
        r.op    = OP_READ;
        r.addr  = 8'h5a;
        r.tag   = 4'h9;
        dir_q1.push_back(r);
        wait_accepts(1, acc_cnt[1] + 1, 50);
        n = 0;
        while (!o_rsp[1].valid) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 50) begin
                $display("single read never came back");
                other_errs++;
                break;
            end
        end
        lat = n;
        if (n != 6) begin
            $display("error: read latency got %h expected %h", n, 6);
            other_errs++;
        end
    endtask

    initial begin
        #200000;
        $display("simulation ran too long and was stopped");
        $display("Test failed");
        $finish;
    end

    initial begin
        mem_req_t r;
        void'($urandom(75348));
        clk       = 1'b0;
        rst       = 1'b1;
        i_req[0]  = '0;
        i_req[1]  = '0;
        i_req[0].valid = 1'b1;   // offered during reset, must not be taken
        i_req[1].valid = 1'b1;
        i_rsp_ack = '0;
        acc_cnt   = '{0, 0};
        last_gnt  = 1;
        rand_en   = 1'b0;
        rd_heavy  = 1'b0;
        ack_mode  = 0;
        rsp_errs  = 0;
        ready_errs = 0;
        other_errs = 0;
        repeat (3) @(posedge clk);
        rst      <= 1'b0;
        i_req[0] <= '0;
        i_req[1] <= '0;
        // idle after reset, nothing offered yet
        repeat (5) begin
            @(posedge clk);
            #1;
            check_ready("o_req_ready after reset", o_req_ready, '0);
            check_rsp(0, o_rsp[0], '0);
            check_rsp(1, o_rsp[1], '0);
        end
        // fill every line through port 0
        for (int a = 0; a < LINES; a++) begin
            r       = '0;
            r.valid = 1'b1;
            r.op    = OP_WRITE;
            r.addr  = ADDR_W'(a);
            r.data  = DATA_W'($urandom);
            dir_q0.push_back(r);
        end
        wait_accepts(0, LINES, 2000);
        wait_drain(200);
        repeat (10) @(posedge clk);
        measure_latency();
        wait_drain(200);
        // random traffic with random acknowledges
        ack_mode = 1;
        rand_en  = 1'b1;
        repeat (400) @(posedge clk);
        // back-pressure, the pipeline must freeze
        ack_mode = 2;
        rd_heavy = 1'b1;
        repeat (30) @(posedge clk);
        repeat (10) begin
            @(posedge clk);
            #1;
            check_ready("o_req_ready while stalled", o_req_ready, '0);
        end
        ack_mode = 1;
        rd_heavy = 1'b0;
        repeat (300) @(posedge clk);
        rand_en  = 1'b0;
        ack_mode = 0;
        wait_drain(500);
        repeat (20) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d reads never came back", exp_q.size());
            other_errs++;
        end
        $display("errors: %0d response, %0d ready, %0d other (latency %0d)",
                 rsp_errs, ready_errs, other_errs, lat);
        if (rsp_errs + ready_errs + other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
